// File: wf_pkg.sv
// Shared widths, register map and types of the wire-frame memory-fill DMA path
package wf_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int P_MEM_ADRS_W  = 20;
  localparam int P_DMA_LEN_W   = 18;
  localparam int P_DATA_W      = 32;
  localparam int P_BE_W        = 4;
  localparam int P_REG_ADRS_W  = 8;

  // Burst shaping
  localparam int P_BURST_MAX   = 8;
  localparam int P_BURST_LEN_W = 4;

  //////////////////////////////
  // Register map
  //////////////////////////////
  localparam logic [P_REG_ADRS_W-1:0] P_REG_CTRL   = 8'h00;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_TOP    = 8'h04;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_LEN    = 8'h08;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_BE     = 8'h0C;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_WD0    = 8'h10;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_WD1    = 8'h14;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_STATUS = 8'h18;
  localparam logic [P_REG_ADRS_W-1:0] P_REG_INT_EN = 8'h1C;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Fill pattern selected by CTRL bits 2:1
  typedef enum logic [1:0] {
    MODE_FILL   = 2'd0,
    MODE_STRIPE = 2'd1,
    MODE_CLEAR  = 2'd2
  } dma_mode_e;

  // Memory writer states
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_REQ  = 2'd1,
    WR_DATA = 2'd2
  } wr_state_e;

  // One fill word on its way to memory
  typedef struct packed {
    logic [P_MEM_ADRS_W-1:0]  adrs;
    // Words in this burst, only meaningful when first is set
    logic [P_BURST_LEN_W-1:0] burst_len;
    logic [P_BE_W-1:0]        be;
    logic [P_DATA_W-1:0]      wd;
    // Opens a burst
    logic                     first;
    // Closes the whole transfer
    logic                     last;
  } fill_word_t;

endpackage

// File: wf_dma_cfg_if.sv
// DMA configuration link from the system controller to the fill generator
interface wf_dma_cfg_if ();
  import wf_pkg::*;

  // One-cycle start pulse
  logic                    start;
  dma_mode_e               mode;
  logic [P_MEM_ADRS_W-1:0] top_adrs;
  // Transfer length in words
  logic [P_DMA_LEN_W-1:0]  length;
  logic [P_BE_W-1:0]       be;
  logic [P_DATA_W-1:0]     wd0;
  logic [P_DATA_W-1:0]     wd1;

  modport regs (
    output start, mode, top_adrs, length, be, wd0, wd1
  );

  modport gen (
    input start, mode, top_adrs, length, be, wd0, wd1
  );

endinterface

// File: wf_sys_regs.sv
// System controller with register bus decode, DMA configuration, busy tracking and interrupt
module wf_sys_regs (
  input  logic                            clk_core,
  input  logic                            i_rst_n,
  // Register bus
  input  logic                            i_req,
  input  logic                            i_wr,
  input  logic [wf_pkg::P_REG_ADRS_W-1:0] i_adrs,
  input  logic [wf_pkg::P_BE_W-1:0]       i_be,
  input  logic [wf_pkg::P_DATA_W-1:0]     i_wd,
  output logic                            o_ack,
  output logic                            o_rstr,
  output logic [wf_pkg::P_DATA_W-1:0]     o_rd,
  // DMA status and interrupt
  input  logic                            i_dma_end,
  output logic                            o_int,
  wf_dma_cfg_if.regs                      cfg
);
  import wf_pkg::*;

  logic [P_DATA_W-1:0]     w_bmask;
  logic                    w_wr_en;
  logic                    w_start_ok;
  logic                    w_clr_pend;
  logic [P_DATA_W-1:0]     w_rd_mux;

  logic                    r_rd_pend;
  logic [P_REG_ADRS_W-1:0] r_rd_adrs;
  dma_mode_e               r_mode;
  logic [P_MEM_ADRS_W-1:0] r_top;
  logic [P_DMA_LEN_W-1:0]  r_len;
  logic [P_BE_W-1:0]       r_be;
  logic [P_DATA_W-1:0]     r_wd0;
  logic [P_DATA_W-1:0]     r_wd1;
  logic                    r_int_en;
  logic                    r_start;
  logic                    r_busy;
  logic                    r_pend;

  // Byte lanes selected by the bus byte enables
  assign w_bmask = {{8{i_be[3]}}, {8{i_be[2]}}, {8{i_be[1]}}, {8{i_be[0]}}};
  assign w_wr_en = i_req & i_wr;

  // Start only from idle with a nonzero length
  assign w_start_ok = w_wr_en & (i_adrs == P_REG_CTRL) & i_be[0] & i_wd[0] &
                      ~r_busy & (r_len != '0);
  assign w_clr_pend = w_wr_en & (i_adrs == P_REG_STATUS) & i_be[0] & i_wd[1];

  //////////////////////////////
  // Bus handshake
  //////////////////////////////
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      o_ack     <= 1'b0;
      o_rstr    <= 1'b0;
      r_rd_pend <= 1'b0;
    end else begin
      o_ack     <= i_req;
      r_rd_pend <= i_req & ~i_wr;
      o_rstr    <= r_rd_pend;
    end
  end

  always_ff @(posedge clk_core) begin
    r_rd_adrs <= i_adrs;
    if (r_rd_pend) begin
      o_rd <= w_rd_mux;
    end
  end

  always_comb begin
    w_rd_mux = '0;
    case (r_rd_adrs)
      P_REG_CTRL:   w_rd_mux[2:1] = r_mode;
      P_REG_TOP:    w_rd_mux[P_MEM_ADRS_W-1:0] = r_top;
      P_REG_LEN:    w_rd_mux[P_DMA_LEN_W-1:0] = r_len;
      P_REG_BE:     w_rd_mux[P_BE_W-1:0] = r_be;
      P_REG_WD0:    w_rd_mux = r_wd0;
      P_REG_WD1:    w_rd_mux = r_wd1;
      P_REG_STATUS: w_rd_mux[1:0] = {r_pend, r_busy};
      P_REG_INT_EN: w_rd_mux[0] = r_int_en;
      default:      w_rd_mux = '0;
    endcase
  end

  //////////////////////////////
  // Configuration registers
  //////////////////////////////
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      r_mode   <= MODE_FILL;
      r_top    <= '0;
      r_len    <= '0;
      r_be     <= '0;
      r_wd0    <= '0;
      r_wd1    <= '0;
      r_int_en <= 1'b0;
    end else if (w_wr_en) begin
      case (i_adrs)
        P_REG_CTRL: begin
          if (i_be[0]) begin
            r_mode <= dma_mode_e'(i_wd[2:1]);
          end
        end
        P_REG_TOP: r_top <= (r_top & ~w_bmask[P_MEM_ADRS_W-1:0]) |
                            (i_wd[P_MEM_ADRS_W-1:0] & w_bmask[P_MEM_ADRS_W-1:0]);
        P_REG_LEN: r_len <= (r_len & ~w_bmask[P_DMA_LEN_W-1:0]) |
                            (i_wd[P_DMA_LEN_W-1:0] & w_bmask[P_DMA_LEN_W-1:0]);
        P_REG_BE:  r_be <= (r_be & ~w_bmask[P_BE_W-1:0]) |
                           (i_wd[P_BE_W-1:0] & w_bmask[P_BE_W-1:0]);
        P_REG_WD0: r_wd0 <= (r_wd0 & ~w_bmask) | (i_wd & w_bmask);
        P_REG_WD1: r_wd1 <= (r_wd1 & ~w_bmask) | (i_wd & w_bmask);
        P_REG_INT_EN: begin
          if (i_be[0]) begin
            r_int_en <= i_wd[0];
          end
        end
        default: r_int_en <= r_int_en;
      endcase
    end
  end

  // Start pulse, busy and interrupt pending
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      r_start <= 1'b0;
      r_busy  <= 1'b0;
      r_pend  <= 1'b0;
    end else begin
      r_start <= w_start_ok;
      if (w_start_ok) begin
        r_busy <= 1'b1;
      end else if (i_dma_end) begin
        r_busy <= 1'b0;
      end
      // A new end event wins over a clear in the same cycle
      if (i_dma_end) begin
        r_pend <= 1'b1;
      end else if (w_clr_pend) begin
        r_pend <= 1'b0;
      end
    end
  end

  assign o_int = r_pend & r_int_en;

  assign cfg.start    = r_start;
  assign cfg.mode     = r_mode;
  assign cfg.top_adrs = r_top;
  assign cfg.length   = r_len;
  assign cfg.be       = r_be;
  assign cfg.wd0      = r_wd0;
  assign cfg.wd1      = r_wd1;

endmodule

// File: wf_fill_gen.sv
// DMA fill engine that produces addressed, patterned words split into bursts
module wf_fill_gen (
  input  logic               clk_core,
  input  logic               i_rst_n,
  wf_dma_cfg_if.gen          cfg,
  // Word FIFO write side
  output logic               o_push,
  output wf_pkg::fill_word_t o_word,
  input  logic               i_full
);
  import wf_pkg::*;

  logic                                r_active;
  logic [P_DMA_LEN_W-1:0]              r_remain;
  logic [$clog2(P_BURST_MAX)-1:0]      r_pos;
  logic                                r_odd;
  logic [P_MEM_ADRS_W-1:0]             r_adrs;
  dma_mode_e                           r_mode;
  logic [P_BE_W-1:0]                   r_be;
  logic [P_DATA_W-1:0]                 r_wd0;
  logic [P_DATA_W-1:0]                 r_wd1;
  logic [P_BURST_LEN_W-1:0]            r_burst_len;

  logic                                w_first;
  logic                                w_last;
  logic [P_BURST_LEN_W-1:0]            w_new_len;
  logic [P_DATA_W-1:0]                 w_data;

  assign o_push  = r_active & ~i_full;
  assign w_first = (r_pos == '0);
  assign w_last  = (r_remain == P_DMA_LEN_W'(1));

  // Burst length at an eight-word boundary
  always_comb begin
    if (r_remain >= P_DMA_LEN_W'(P_BURST_MAX)) begin
      w_new_len = P_BURST_LEN_W'(P_BURST_MAX);
    end else begin
      w_new_len = r_remain[P_BURST_LEN_W-1:0];
    end
  end

  // Data pattern by mode and offset parity
  always_comb begin
    case (r_mode)
      MODE_FILL:   w_data = r_wd0;
      MODE_STRIPE: w_data = r_odd ? r_wd1 : r_wd0;
      default:     w_data = '0;
    endcase
  end

  always_comb begin
    o_word.adrs      = r_adrs;
    o_word.burst_len = w_first ? w_new_len : r_burst_len;
    o_word.be        = r_be;
    o_word.wd        = w_data;
    o_word.first     = w_first;
    o_word.last      = w_last;
  end

  //////////////////////////////
  // Transfer control
  //////////////////////////////
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      r_active <= 1'b0;
      r_remain <= '0;
      r_pos    <= '0;
      r_odd    <= 1'b0;
    end else if (cfg.start) begin
      r_active <= 1'b1;
      r_remain <= cfg.length;
      r_pos    <= '0;
      r_odd    <= 1'b0;
    end else if (o_push) begin
      r_remain <= r_remain - 1'b1;
      r_pos    <= r_pos + 1'b1;
      r_odd    <= ~r_odd;
      if (w_last) begin
        r_active <= 1'b0;
      end
    end
  end

  // Latched configuration and running address
  always_ff @(posedge clk_core) begin
    if (cfg.start) begin
      r_adrs <= cfg.top_adrs;
      r_mode <= cfg.mode;
      r_be   <= cfg.be;
      r_wd0  <= cfg.wd0;
      r_wd1  <= cfg.wd1;
    end else if (o_push) begin
      r_adrs <= r_adrs + 1'b1;
      if (w_first) begin
        r_burst_len <= w_new_len;
      end
    end
  end

endmodule

// File: wf_word_fifo.sv
// Synchronous FIFO of fill words between the generator and the memory writer
module wf_word_fifo #(
  parameter int P_DEPTH = 16
) (
  input  logic               clk_core,
  input  logic               i_rst_n,
  // Write side
  input  logic               i_push,
  input  wf_pkg::fill_word_t i_word,
  output logic               o_full,
  // Read side
  input  logic               i_pop,
  output logic               o_valid,
  output wf_pkg::fill_word_t o_word
);
  import wf_pkg::*;

  fill_word_t                   r_mem [P_DEPTH];
  logic [$clog2(P_DEPTH)-1:0]   r_wp;
  logic [$clog2(P_DEPTH)-1:0]   r_rp;
  logic [$clog2(P_DEPTH):0]     r_cnt;
  logic                         w_do_push;
  logic                         w_do_pop;

  assign o_full    = (r_cnt == P_DEPTH);
  assign o_valid   = (r_cnt != '0);
  assign w_do_push = i_push & ~o_full;
  assign w_do_pop  = i_pop & o_valid;
  assign o_word    = r_mem[r_rp];

  always_ff @(posedge clk_core) begin
    if (w_do_push) begin
      r_mem[r_wp] <= i_word;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      r_wp  <= '0;
      r_rp  <= '0;
      r_cnt <= '0;
    end else begin
      if (w_do_push) begin
        r_wp <= r_wp + 1'b1;
      end
      if (w_do_pop) begin
        r_rp <= r_rp + 1'b1;
      end
      case ({w_do_push, w_do_pop})
        2'b10:   r_cnt <= r_cnt + 1'b1;
        2'b01:   r_cnt <= r_cnt - 1'b1;
        default: r_cnt <= r_cnt;
      endcase
    end
  end

endmodule

// File: wf_mem_writer.sv
// Memory write port that issues bursts and streams fill words to external memory
module wf_mem_writer (
  input  logic                             clk_core,
  input  logic                             i_rst_n,
  // Word FIFO read side
  input  logic                             i_valid,
  input  wf_pkg::fill_word_t               i_word,
  output logic                             o_pop,
  // Memory port
  output logic                             o_req_mem,
  output logic [wf_pkg::P_MEM_ADRS_W-1:0]  o_adrs_mem,
  output logic [wf_pkg::P_BURST_LEN_W-1:0] o_len_mem,
  input  logic                             i_ack_mem,
  output logic                             o_strw_mem,
  output logic [wf_pkg::P_BE_W-1:0]        o_be_mem,
  output logic [wf_pkg::P_DATA_W-1:0]      o_wd_mem,
  input  logic                             i_ackw_mem,
  // Transfer done
  output logic                             o_dma_end
);
  import wf_pkg::*;

  wr_state_e                r_state;
  logic [P_MEM_ADRS_W-1:0]  r_adrs;
  logic [P_BURST_LEN_W-1:0] r_len;
  // Words already taken in this burst
  logic [P_BURST_LEN_W-1:0] r_cnt;
  logic                     w_burst_done;

  assign o_req_mem    = (r_state == WR_REQ);
  assign o_adrs_mem   = r_adrs;
  assign o_len_mem    = r_len;
  assign o_strw_mem   = (r_state == WR_DATA) & i_valid;
  assign o_be_mem     = i_word.be;
  assign o_wd_mem     = i_word.wd;
  assign o_pop        = o_strw_mem & i_ackw_mem;
  assign o_dma_end    = o_pop & i_word.last;
  assign w_burst_done = o_pop & (r_cnt == r_len - 1'b1);

  //////////////////////////////
  // Burst FSM
  //////////////////////////////
  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      r_state <= WR_IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        WR_IDLE: begin
          r_cnt <= '0;
          if (i_valid && i_word.first) begin
            r_state <= WR_REQ;
          end
        end
        WR_REQ: begin
          if (i_ack_mem) begin
            r_state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_burst_done) begin
            r_state <= WR_IDLE;
          end else if (o_pop) begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        default: r_state <= WR_IDLE;
      endcase
    end
  end

  // Burst header from the head entry
  always_ff @(posedge clk_core) begin
    if (r_state == WR_IDLE && i_valid && i_word.first) begin
      r_adrs <= i_word.adrs;
      r_len  <= i_word.burst_len;
    end
  end

endmodule

// File: wf_fill_top.sv
// Top level of the memory-fill DMA path with register bus and memory write port
module wf_fill_top (
  input  logic                             clk_core,
  input  logic                             i_rst_n,
  // Register bus
  input  logic                             i_req,
  input  logic                             i_wr,
  input  logic [wf_pkg::P_REG_ADRS_W-1:0]  i_adrs,
  input  logic [wf_pkg::P_BE_W-1:0]        i_be,
  input  logic [wf_pkg::P_DATA_W-1:0]      i_wd,
  output logic                             o_ack,
  output logic                             o_rstr,
  output logic [wf_pkg::P_DATA_W-1:0]      o_rd,
  // Memory port
  output logic                             o_req_mem,
  output logic [wf_pkg::P_MEM_ADRS_W-1:0]  o_adrs_mem,
  output logic [wf_pkg::P_BURST_LEN_W-1:0] o_len_mem,
  input  logic                             i_ack_mem,
  output logic                             o_strw_mem,
  output logic [wf_pkg::P_BE_W-1:0]        o_be_mem,
  output logic [wf_pkg::P_DATA_W-1:0]      o_wd_mem,
  input  logic                             i_ackw_mem,
  // Interrupt
  output logic                             o_int
);
  import wf_pkg::*;

  //////////////////////////////
  // Internal links
  //////////////////////////////
  logic       w_dma_end;
  logic       w_push;
  fill_word_t w_push_word;
  logic       w_full;
  logic       w_head_valid;
  fill_word_t w_head_word;
  logic       w_pop;

  wf_dma_cfg_if u_cfg_if ();

  wf_sys_regs u_sys_regs (
    .clk_core (clk_core),
    .i_rst_n  (i_rst_n),
    .i_req    (i_req),
    .i_wr     (i_wr),
    .i_adrs   (i_adrs),
    .i_be     (i_be),
    .i_wd     (i_wd),
    .o_ack    (o_ack),
    .o_rstr   (o_rstr),
    .o_rd     (o_rd),
    .i_dma_end(w_dma_end),
    .o_int    (o_int),
    .cfg      (u_cfg_if.regs)
  );

  wf_fill_gen u_fill_gen (
    .clk_core(clk_core),
    .i_rst_n (i_rst_n),
    .cfg     (u_cfg_if.gen),
    .o_push  (w_push),
    .o_word  (w_push_word),
    .i_full  (w_full)
  );

  wf_word_fifo u_word_fifo (
    .clk_core(clk_core),
    .i_rst_n (i_rst_n),
    .i_push  (w_push),
    .i_word  (w_push_word),
    .o_full  (w_full),
    .i_pop   (w_pop),
    .o_valid (w_head_valid),
    .o_word  (w_head_word)
  );

  wf_mem_writer u_mem_writer (
    .clk_core  (clk_core),
    .i_rst_n   (i_rst_n),
    .i_valid   (w_head_valid),
    .i_word    (w_head_word),
    .o_pop     (w_pop),
    .o_req_mem (o_req_mem),
    .o_adrs_mem(o_adrs_mem),
    .o_len_mem (o_len_mem),
    .i_ack_mem (i_ack_mem),
    .o_strw_mem(o_strw_mem),
    .o_be_mem  (o_be_mem),
    .o_wd_mem  (o_wd_mem),
    .i_ackw_mem(i_ackw_mem),
    .o_dma_end (w_dma_end)
  );

endmodule

// File: tb_mem_model.sv
// Memory responder for the fill path that acknowledges after random delays and logs writes
module tb_mem_model (
  input  logic                             clk_core,
  input  logic                             i_rst_n,
  // Burst request
  input  logic                             i_req_mem,
  input  logic [wf_pkg::P_MEM_ADRS_W-1:0]  i_adrs_mem,
  input  logic [wf_pkg::P_BURST_LEN_W-1:0] i_len_mem,
  output logic                             o_ack_mem,
  // Word stream
  input  logic                             i_strw_mem,
  input  logic [wf_pkg::P_BE_W-1:0]        i_be_mem,
  input  logic [wf_pkg::P_DATA_W-1:0]      i_wd_mem,
  output logic                             o_ackw_mem,
  // Log fill levels
  output int                               o_burst_cnt,
  output int                               o_word_cnt
);
  import wf_pkg::*;

  localparam int P_LOG = 256;

  // Logged bursts and words, read by the testbench
  logic [P_MEM_ADRS_W-1:0]  burst_adrs [P_LOG];
  logic [P_BURST_LEN_W-1:0] burst_len  [P_LOG];
  logic [P_MEM_ADRS_W-1:0]  word_adrs  [P_LOG];
  logic [P_DATA_W-1:0]      word_data  [P_LOG];
  logic [P_BE_W-1:0]        word_be    [P_LOG];

  logic [31:0]             r_seed;
  logic [31:0]             w_seed_next;
  logic [1:0]              r_wait;
  logic [P_MEM_ADRS_W-1:0] r_next_adrs;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign w_seed_next = lcg_next(r_seed);

  always_ff @(posedge clk_core) begin
    if (!i_rst_n) begin
      o_ack_mem   <= 1'b0;
      o_ackw_mem  <= 1'b0;
      o_burst_cnt <= 0;
      o_word_cnt  <= 0;
      r_seed      <= 32'd43798;
      r_wait      <= 2'd0;
      r_next_adrs <= '0;
    end else begin
      o_ack_mem  <= 1'b0;
      o_ackw_mem <= 1'b0;
      if (o_ackw_mem && i_strw_mem) begin
        // Word taken in this cycle
        if (o_word_cnt < P_LOG) begin
          word_adrs[o_word_cnt] <= r_next_adrs;
          word_data[o_word_cnt] <= i_wd_mem;
          word_be[o_word_cnt]   <= i_be_mem;
        end
        o_word_cnt  <= o_word_cnt + 1;
        r_next_adrs <= r_next_adrs + 1'b1;
      end else if (i_req_mem && !o_ack_mem) begin
        if (r_wait == 2'd0) begin
          o_ack_mem <= 1'b1;
          if (o_burst_cnt < P_LOG) begin
            burst_adrs[o_burst_cnt] <= i_adrs_mem;
            burst_len[o_burst_cnt]  <= i_len_mem;
          end
          o_burst_cnt <= o_burst_cnt + 1;
          r_next_adrs <= i_adrs_mem;
          r_seed      <= w_seed_next;
          r_wait      <= w_seed_next[17:16];
        end else begin
          r_wait <= r_wait - 1'b1;
        end
      end else if (i_strw_mem && !o_ackw_mem) begin
        if (r_wait == 2'd0) begin
          o_ackw_mem <= 1'b1;
          r_seed     <= w_seed_next;
          r_wait     <= w_seed_next[17:16];
        end else begin
          r_wait <= r_wait - 1'b1;
        end
      end
    end
  end

endmodule

// File: tb_wf_fill.sv
// Testbench for the memory-fill DMA path with register access and directed transfer tests
module tb_wf_fill;
  import wf_pkg::*;

  localparam int P_CLK_PER     = 100;
  localparam int P_BUS_TIMEOUT = 20;
  localparam int P_POLL_MAX    = 400;
  localparam int P_QUIET_CYC   = 40;

  logic                     clk_core;
  logic                     i_rst_n;
  logic                     i_req;
  logic                     i_wr;
  logic [P_REG_ADRS_W-1:0]  i_adrs;
  logic [P_BE_W-1:0]        i_be;
  logic [P_DATA_W-1:0]      i_wd;
  logic                     o_ack;
  logic                     o_rstr;
  logic [P_DATA_W-1:0]      o_rd;
  logic                     o_req_mem;
  logic [P_MEM_ADRS_W-1:0]  o_adrs_mem;
  logic [P_BURST_LEN_W-1:0] o_len_mem;
  logic                     i_ack_mem;
  logic                     o_strw_mem;
  logic [P_BE_W-1:0]        o_be_mem;
  logic [P_DATA_W-1:0]      o_wd_mem;
  logic                     i_ackw_mem;
  logic                     o_int;
  int                       burst_cnt;
  int                       word_cnt;

  int err_cnt;
  int test_cnt;
  int test_err_base;

  wf_fill_top dut (.*);

  tb_mem_model u_mem (
    .clk_core   (clk_core),
    .i_rst_n    (i_rst_n),
    .i_req_mem  (o_req_mem),
    .i_adrs_mem (o_adrs_mem),
    .i_len_mem  (o_len_mem),
    .o_ack_mem  (i_ack_mem),
    .i_strw_mem (o_strw_mem),
    .i_be_mem   (o_be_mem),
    .i_wd_mem   (o_wd_mem),
    .o_ackw_mem (i_ackw_mem),
    .o_burst_cnt(burst_cnt),
    .o_word_cnt (word_cnt)
  );

  initial begin
    clk_core = 1'b0;
    forever #(P_CLK_PER / 2) clk_core = ~clk_core;
  end

  // Hard stop in case a loop bound is ever missed
  initial begin
    repeat (200000) @(posedge clk_core);
    $display("simulation watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////
  task automatic check_reg(input string name, input logic [P_DATA_W-1:0] got,
                           input logic [P_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got 0x%0h exp 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(input int idx, input fill_word_t got, input fill_word_t exp);
    if (got.adrs !== exp.adrs) begin
      $display("ERROR t=%0t word[%0d].adrs got 0x%0h exp 0x%0h", $time, idx, got.adrs, exp.adrs);
      err_cnt++;
    end
    if (got.wd !== exp.wd) begin
      $display("ERROR t=%0t word[%0d].wd got 0x%0h exp 0x%0h", $time, idx, got.wd, exp.wd);
      err_cnt++;
    end
    if (got.be !== exp.be) begin
      $display("ERROR t=%0t word[%0d].be got 0x%0h exp 0x%0h", $time, idx, got.be, exp.be);
      err_cnt++;
    end
  endtask

  task automatic check_burst(input int idx,
                             input logic [P_MEM_ADRS_W-1:0] got_adrs,
                             input logic [P_MEM_ADRS_W-1:0] exp_adrs,
                             input logic [P_BURST_LEN_W-1:0] got_len,
                             input logic [P_BURST_LEN_W-1:0] exp_len);
    if (got_adrs !== exp_adrs) begin
      $display("ERROR t=%0t burst[%0d].adrs got 0x%0h exp 0x%0h", $time, idx, got_adrs, exp_adrs);
      err_cnt++;
    end
    if (got_len !== exp_len) begin
      $display("ERROR t=%0t burst[%0d].len got %0d exp %0d", $time, idx, got_len, exp_len);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s got %0d exp %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////
  // Register bus access
  ////////////////////////////////
  task automatic reg_write(input logic [P_REG_ADRS_W-1:0] adrs,
                           input logic [P_DATA_W-1:0] data, input logic [P_BE_W-1:0] be);
    int n;
    @(posedge clk_core);
    i_req  <= 1'b1;
    i_wr   <= 1'b1;
    i_adrs <= adrs;
    i_be   <= be;
    i_wd   <= data;
    @(posedge clk_core);
    i_req <= 1'b0;
    i_wr  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_core);
      n++;
    end while (!o_ack && n < P_BUS_TIMEOUT);
    if (!o_ack) begin
      $display("register write to 0x%0h was never acknowledged", adrs);
      err_cnt++;
    end
  endtask

  task automatic reg_read(input logic [P_REG_ADRS_W-1:0] adrs,
                          output logic [P_DATA_W-1:0] data);
    int n;
    data = '0;
    @(posedge clk_core);
    i_req  <= 1'b1;
    i_wr   <= 1'b0;
    i_adrs <= adrs;
    i_be   <= 4'hF;
    @(posedge clk_core);
    i_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_core);
      n++;
    end while (!o_ack && n < P_BUS_TIMEOUT);
    if (!o_ack) begin
      $display("register read of 0x%0h was never acknowledged", adrs);
      err_cnt++;
    end else begin
      n = 0;
      do begin
        @(negedge clk_core);
        n++;
      end while (!o_rstr && n < P_BUS_TIMEOUT);
      if (!o_rstr) begin
        $display("register read of 0x%0h returned no read strobe", adrs);
        err_cnt++;
      end else begin
        data = o_rd;
      end
    end
  endtask

  task automatic write_readback(input string name, input logic [P_REG_ADRS_W-1:0] adrs,
                                input logic [P_DATA_W-1:0] data, input logic [P_BE_W-1:0] be,
                                input logic [P_DATA_W-1:0] exp);
    logic [P_DATA_W-1:0] rd;
    reg_write(adrs, data, be);
    reg_read(adrs, rd);
    check_reg(name, rd, exp);
  endtask

  // Poll STATUS until busy clears
  task automatic wait_idle;
    logic [P_DATA_W-1:0] st;
    int n;
    st = 32'h1;
    n = 0;
    while (st[0] && n < P_POLL_MAX) begin
      reg_read(P_REG_STATUS, st);
      n++;
    end
    if (st[0]) begin
      $display("transfer did not finish, STATUS busy still set after %0d polls", n);
      err_cnt++;
    end
  endtask

  ////////////////////////////////
  // Transfer helpers
  ////////////////////////////////
  function automatic logic [P_DATA_W-1:0] expected_data(input dma_mode_e mode, input int k,
                                                         input logic [P_DATA_W-1:0] wd0,
                                                         input logic [P_DATA_W-1:0] wd1);
    case (mode)
      MODE_FILL:   return wd0;
      MODE_STRIPE: return (k % 2 == 1) ? wd1 : wd0;
      default:     return '0;
    endcase
  endfunction

  task automatic start_dma(input dma_mode_e mode);
    reg_write(P_REG_CTRL, {29'd0, mode, 1'b1}, 4'h1);
  endtask

  task automatic run_transfer(input logic [P_MEM_ADRS_W-1:0] top, input int len,
                              input dma_mode_e mode, input logic [P_BE_W-1:0] be,
                              input logic [P_DATA_W-1:0] wd0, input logic [P_DATA_W-1:0] wd1);
    int bb;
    int wb;
    int nb;
    fill_word_t got;
    fill_word_t exp;
    logic [P_BURST_LEN_W-1:0] exp_len;
    reg_write(P_REG_TOP, 32'(top), 4'hF);
    reg_write(P_REG_LEN, len, 4'hF);
    reg_write(P_REG_BE, 32'(be), 4'hF);
    reg_write(P_REG_WD0, wd0, 4'hF);
    reg_write(P_REG_WD1, wd1, 4'hF);
    bb = burst_cnt;
    wb = word_cnt;
    start_dma(mode);
    wait_idle();
    nb = (len + P_BURST_MAX - 1) / P_BURST_MAX;
    check_count("burst count", burst_cnt - bb, nb);
    check_count("word count", word_cnt - wb, len);
    for (int b = 0; b < nb && b < burst_cnt - bb; b++) begin
      exp_len = (len - 8 * b >= 8) ? 4'd8 : P_BURST_LEN_W'(len - 8 * b);
      check_burst(b, u_mem.burst_adrs[bb + b], top + P_MEM_ADRS_W'(8 * b),
                  u_mem.burst_len[bb + b], exp_len);
    end
    for (int k = 0; k < len && k < word_cnt - wb; k++) begin
      got      = '0;
      got.adrs = u_mem.word_adrs[wb + k];
      got.wd   = u_mem.word_data[wb + k];
      got.be   = u_mem.word_be[wb + k];
      exp      = '0;
      exp.adrs = top + P_MEM_ADRS_W'(k);
      exp.wd   = expected_data(mode, k, wd0, wd1);
      exp.be   = be;
      check_word(k, got, exp);
    end
  endtask

  task automatic begin_test;
    test_err_base = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////
  task automatic test_reg_access;
    logic [P_DATA_W-1:0] rd;
    begin_test();
    reg_read(P_REG_STATUS, rd);
    check_reg("STATUS after reset", rd, 32'h0);
    write_readback("TOP", P_REG_TOP, 32'hFFFF_FFFF, 4'hF, 32'h000F_FFFF);
    write_readback("LEN", P_REG_LEN, 32'hFFFF_FFFF, 4'hF, 32'h0003_FFFF);
    write_readback("BE", P_REG_BE, 32'hFFFF_FFFF, 4'hF, 32'h0000_000F);
    write_readback("WD0", P_REG_WD0, 32'hA5A5_1234, 4'hF, 32'hA5A5_1234);
    // Only the two low byte lanes change
    write_readback("WD0 lanes", P_REG_WD0, 32'hFFFF_FFFF, 4'b0011, 32'hA5A5_FFFF);
    write_readback("WD1", P_REG_WD1, 32'h5A5A_8765, 4'hF, 32'h5A5A_8765);
    write_readback("INT_EN", P_REG_INT_EN, 32'hFFFF_FFFF, 4'hF, 32'h0000_0001);
    write_readback("unmapped", 8'h40, 32'hFFFF_FFFF, 4'hF, 32'h0);
    reg_write(P_REG_INT_EN, 32'h0, 4'hF);
    end_test("reg_access");
  endtask

  task automatic test_irq_busy;
    logic [P_DATA_W-1:0] rd;
    int wb;
    int n;
    begin_test();
    // Earlier transfers left pending set
    reg_write(P_REG_STATUS, 32'h2, 4'h1);
    reg_write(P_REG_INT_EN, 32'h1, 4'hF);
    @(negedge clk_core);
    check_reg("o_int before transfer", {31'd0, o_int}, 32'h0);
    run_transfer(20'h0_0400, 4, MODE_FILL, 4'hF, 32'h0BAD_F00D, 32'h0);
    @(negedge clk_core);
    check_reg("o_int", {31'd0, o_int}, 32'h1);
    reg_read(P_REG_STATUS, rd);
    check_reg("STATUS after end", rd, 32'h2);
    reg_write(P_REG_STATUS, 32'h2, 4'h1);
    @(negedge clk_core);
    check_reg("o_int after clear", {31'd0, o_int}, 32'h0);
    reg_read(P_REG_STATUS, rd);
    check_reg("STATUS after clear", rd, 32'h0);
    // Interrupt masked
    reg_write(P_REG_INT_EN, 32'h0, 4'hF);
    run_transfer(20'h0_0500, 3, MODE_FILL, 4'h3, 32'h7777_0000, 32'h0);
    @(negedge clk_core);
    check_reg("o_int masked", {31'd0, o_int}, 32'h0);
    reg_write(P_REG_STATUS, 32'h2, 4'h1);
    // Second start while busy
    reg_write(P_REG_LEN, 32'd16, 4'hF);
    wb = word_cnt;
    start_dma(MODE_FILL);
    start_dma(MODE_FILL);
    wait_idle();
    check_count("words after busy start", word_cnt - wb, 16);
    reg_write(P_REG_STATUS, 32'h2, 4'h1);
    // Start with zero length
    reg_write(P_REG_LEN, 32'd0, 4'hF);
    wb = word_cnt;
    start_dma(MODE_FILL);
    reg_read(P_REG_STATUS, rd);
    check_reg("STATUS after zero start", rd, 32'h0);
    // Watch the memory port for stray words
    n = 0;
    while (word_cnt == wb && n < P_QUIET_CYC) begin
      @(negedge clk_core);
      n++;
    end
    check_count("words after zero start", word_cnt - wb, 0);
    end_test("irq_busy");
  endtask

  initial begin
    err_cnt  = 0;
    test_cnt = 0;
    i_rst_n  = 1'b0;
    i_req    = 1'b0;
    i_wr     = 1'b0;
    i_adrs   = '0;
    i_be     = '0;
    i_wd     = '0;
    repeat (16) @(posedge clk_core);
    i_rst_n <= 1'b1;

    test_reg_access();
    begin_test();
    run_transfer(20'h0_0100, 20, MODE_FILL, 4'h5, 32'hCAFE_0001, 32'h1111_2222);
    end_test("fill");
    begin_test();
    run_transfer(20'h0_3FF8, 13, MODE_STRIPE, 4'hF, 32'h1357_9BDF, 32'h2468_ACE0);
    end_test("stripe");
    begin_test();
    run_transfer(20'h0_8000, 9, MODE_CLEAR, 4'hA, 32'hFFFF_FFFF, 32'hEEEE_EEEE);
    end_test("clear");
    test_irq_busy();

    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: wf_fill_top.f
wf_pkg.sv
wf_dma_cfg_if.sv
wf_sys_regs.sv
wf_fill_gen.sv
wf_word_fifo.sv
wf_mem_writer.sv
wf_fill_top.sv
tb_mem_model.sv
tb_wf_fill.sv

// File: Bender.yml
package:
  name: wf_fill

sources:
  - wf_pkg.sv
  - wf_dma_cfg_if.sv
  - wf_sys_regs.sv
  - wf_fill_gen.sv
  - wf_word_fifo.sv
  - wf_mem_writer.sv
  - wf_fill_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_wf_fill.sv
